// ==== logic/rv_word_pkg.sv ====
package rv_word_pkg;

    localparam int WORD_WIDTH        = 32;
    localparam int SIGNED_WORD_WIDTH = WORD_WIDTH + 1;         // one extra bit for sign extension
    localparam int PRODUCT_WIDTH     = 2 * SIGNED_WORD_WIDTH;  // 33 x 33 signed product
    localparam int HALF_WIDTH        = WORD_WIDTH / 2;         // split point of the multiplier
    localparam int SHAMT_WIDTH       = $clog2(WORD_WIDTH);

    // restoring divider produces one quotient bit per cycle
    localparam int DIV_STEPS         = WORD_WIDTH;
    localparam int DIV_CNT_WIDTH     = $clog2(DIV_STEPS);

    // data word, register and immediate operands
    typedef logic [WORD_WIDTH-1:0] word_t;

    // shift amount taken from the low bits of an operand
    typedef logic [SHAMT_WIDTH-1:0] shamt_t;

    // multiplier addends and their sum
    typedef logic [PRODUCT_WIDTH-1:0] product_t;

endpackage

// ==== logic/alu_op_pkg.sv ====
package alu_op_pkg;

    typedef enum logic [4:0] {
        ALU_OP_NOP = 5'd0,
        // immediate forms, alu_in_0 holds the immediate
        ALU_OP_ADDI,
        ALU_OP_SLTI,
        ALU_OP_SLTIU,
        ALU_OP_ANDI,
        ALU_OP_ORI,
        ALU_OP_XORI,
        ALU_OP_SLLI,
        ALU_OP_SRLI,
        ALU_OP_SRAI,
        ALU_OP_LUI,
        ALU_OP_AUIPC,
        // register forms
        ALU_OP_ADD,
        ALU_OP_SUB,
        ALU_OP_SLT,
        ALU_OP_SLTU,
        ALU_OP_AND,
        ALU_OP_OR,
        ALU_OP_XOR,
        ALU_OP_SLL,
        ALU_OP_SRL,
        ALU_OP_SRA,
        // RV32M multiply
        ALU_OP_MUL,
        ALU_OP_MULH,
        ALU_OP_MULHSU,
        ALU_OP_MULHU,
        // RV32M divide and remainder
        ALU_OP_DIV,
        ALU_OP_DIVU,
        ALU_OP_REM,
        ALU_OP_REMU
    } alu_op_e;

    typedef enum logic [2:0] {
        MUL_OP_NOP    = 3'd0,
        MUL_OP_MUL    = 3'd1,
        MUL_OP_MULH   = 3'd2,
        MUL_OP_MULHU  = 3'd3,
        MUL_OP_MULHSU = 3'd4
    } mul_op_e;

    // rem and remu share the divider with div and divu
    typedef enum logic [1:0] {
        DIV_OP_NOP  = 2'd0,
        DIV_OP_DIV  = 2'd1,
        DIV_OP_DIVU = 2'd2
    } div_op_e;

endpackage

// ==== logic/mul_unit.sv ====
`timescale 1ns/1ps

module mul_unit (
    input  alu_op_pkg::mul_op_e   mul_op,
    input  rv_word_pkg::word_t    mul_data1,
    input  rv_word_pkg::word_t    mul_data2,
    output rv_word_pkg::product_t mul_add_a,
    output rv_word_pkg::product_t mul_add_b
);

    logic                                             sign_1;  // mul_data1 taken as signed
    logic                                             sign_2;  // mul_data2 taken as signed
    logic signed [rv_word_pkg::SIGNED_WORD_WIDTH-1:0] ext_1;
    logic signed [rv_word_pkg::SIGNED_WORD_WIDTH-1:0] ext_2;
    logic signed [rv_word_pkg::HALF_WIDTH:0]          half_lo;
    logic signed [rv_word_pkg::HALF_WIDTH:0]          half_hi;
    logic signed [rv_word_pkg::PRODUCT_WIDTH-1:0]     part_lo;
    logic signed [rv_word_pkg::PRODUCT_WIDTH-1:0]     part_hi;

    always_comb begin
        case (mul_op)
            alu_op_pkg::MUL_OP_MULH: begin
                sign_1 = 1'b1;
                sign_2 = 1'b1;
            end
            alu_op_pkg::MUL_OP_MULHSU: begin
                sign_1 = 1'b1;
                sign_2 = 1'b0;
            end
            default: begin  // low word of mul does not depend on signedness
                sign_1 = 1'b0;
                sign_2 = 1'b0;
            end
        endcase
    end

    assign ext_1 = {sign_1 & mul_data1[rv_word_pkg::WORD_WIDTH-1], mul_data1};
    assign ext_2 = {sign_2 & mul_data2[rv_word_pkg::WORD_WIDTH-1], mul_data2};

    // ext_2 = half_hi * 2^16 + half_lo, with the low half always non-negative
    assign half_lo = {1'b0, ext_2[rv_word_pkg::HALF_WIDTH-1:0]};
    assign half_hi = ext_2[rv_word_pkg::SIGNED_WORD_WIDTH-1:rv_word_pkg::HALF_WIDTH];

    assign part_lo = ext_1 * half_lo;
    assign part_hi = ext_1 * half_hi;

    assign mul_add_a = (mul_op == alu_op_pkg::MUL_OP_NOP) ? '0 :
                       rv_word_pkg::product_t'(part_lo);
    assign mul_add_b = (mul_op == alu_op_pkg::MUL_OP_NOP) ? '0 :
                       rv_word_pkg::product_t'(part_hi <<< rv_word_pkg::HALF_WIDTH);

endmodule

// ==== logic/div_unit.sv ====
`timescale 1ns/1ps

module div_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                div_start,
    input  alu_op_pkg::div_op_e div_op,
    input  rv_word_pkg::word_t  dividend,
    input  rv_word_pkg::word_t  divisor,
    output rv_word_pkg::word_t  quotient,
    output rv_word_pkg::word_t  remainder,
    output logic                div_finish
);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

    div_state_e                            state;
    logic [rv_word_pkg::DIV_CNT_WIDTH-1:0] step_cnt;

    logic                                  is_signed;
    logic                                  neg_dividend;
    logic                                  neg_divisor;
    rv_word_pkg::word_t                    dividend_mag;
    rv_word_pkg::word_t                    divisor_mag;

    rv_word_pkg::word_t                    quo_q;  // dividend bits shift out as quotient bits shift in
    rv_word_pkg::word_t                    rem_q;  // partial remainder
    rv_word_pkg::word_t                    dvs_q;
    logic                                  neg_quo;
    logic                                  neg_rem;

    logic [rv_word_pkg::WORD_WIDTH:0]      shifted;
    logic                                  step_fit;

    assign is_signed    = (div_op == alu_op_pkg::DIV_OP_DIV);
    assign neg_dividend = is_signed & dividend[rv_word_pkg::WORD_WIDTH-1];
    assign neg_divisor  = is_signed & divisor[rv_word_pkg::WORD_WIDTH-1];
    assign dividend_mag = neg_dividend ? -dividend : dividend;  // 0x80000000 stays as 2^31
    assign divisor_mag  = neg_divisor ? -divisor : divisor;

    assign shifted  = {rem_q, quo_q[rv_word_pkg::WORD_WIDTH-1]};
    assign step_fit = (shifted >= {1'b0, dvs_q});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= DIV_IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (div_start) begin
                        state    <= DIV_RUN;
                        step_cnt <= '0;
                    end
                end
                DIV_RUN: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == rv_word_pkg::DIV_CNT_WIDTH'(rv_word_pkg::DIV_STEPS - 1)) begin
                        state <= DIV_DONE;
                    end
                end
                DIV_DONE: state <= DIV_IDLE;
                default:  state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && div_start) begin
            quo_q   <= dividend_mag;
            rem_q   <= '0;
            dvs_q   <= divisor_mag;
            // a zero divisor keeps the quotient at all ones
            neg_quo <= (neg_dividend ^ neg_divisor) && (divisor != '0);
            neg_rem <= neg_dividend;  // remainder takes the dividend sign
        end else if (state == DIV_RUN) begin
            quo_q <= {quo_q[rv_word_pkg::WORD_WIDTH-2:0], step_fit};
            if (step_fit) begin
                rem_q <= rv_word_pkg::word_t'(shifted - {1'b0, dvs_q});
            end else begin
                rem_q <= shifted[rv_word_pkg::WORD_WIDTH-1:0];
            end
        end
    end

    // most negative / -1 gives 2^31 from the magnitudes with no sign flip
    assign quotient   = neg_quo ? -quo_q : quo_q;
    assign remainder  = neg_rem ? -rem_q : rem_q;
    assign div_finish = (state == DIV_DONE);

    a_start_in_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        div_start |-> (state == DIV_IDLE)
    );

    a_finish_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        div_start |-> ##(rv_word_pkg::DIV_STEPS + 1) div_finish
    );

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic                clk,
    input  logic                rst_n,
    input  alu_op_pkg::alu_op_e alu_op,
    input  rv_word_pkg::word_t  alu_in_0,
    input  rv_word_pkg::word_t  alu_in_1,
    output rv_word_pkg::word_t  alu_out,
    output logic                div_in_alu  // stall request to the pipeline
);

    alu_op_pkg::mul_op_e   mul_op;
    rv_word_pkg::product_t mul_add_a;
    rv_word_pkg::product_t mul_add_b;
    rv_word_pkg::product_t mul_sum;

    alu_op_pkg::div_op_e   div_op;
    logic                  div_start;
    logic                  div_finish;
    logic                  div_busy;
    rv_word_pkg::word_t    quotient;
    rv_word_pkg::word_t    remainder;

    rv_word_pkg::shamt_t   shamt_imm;  // immediate in alu_in_0
    rv_word_pkg::shamt_t   shamt_reg;  // rs2 in alu_in_1

    always_comb begin
        case (alu_op)
            alu_op_pkg::ALU_OP_MUL:    mul_op = alu_op_pkg::MUL_OP_MUL;
            alu_op_pkg::ALU_OP_MULH:   mul_op = alu_op_pkg::MUL_OP_MULH;
            alu_op_pkg::ALU_OP_MULHU:  mul_op = alu_op_pkg::MUL_OP_MULHU;
            alu_op_pkg::ALU_OP_MULHSU: mul_op = alu_op_pkg::MUL_OP_MULHSU;
            default:                   mul_op = alu_op_pkg::MUL_OP_NOP;
        endcase
    end

    always_comb begin
        case (alu_op)
            alu_op_pkg::ALU_OP_DIV,
            alu_op_pkg::ALU_OP_REM:  div_op = alu_op_pkg::DIV_OP_DIV;
            alu_op_pkg::ALU_OP_DIVU,
            alu_op_pkg::ALU_OP_REMU: div_op = alu_op_pkg::DIV_OP_DIVU;
            default:                 div_op = alu_op_pkg::DIV_OP_NOP;
        endcase
    end

    assign mul_sum = mul_add_a + mul_add_b;

    assign div_start  = (div_op != alu_op_pkg::DIV_OP_NOP) && !div_busy;
    assign div_in_alu = (div_busy || div_start) && !div_finish;

    mul_unit u_mul (
        .mul_op    (mul_op),
        .mul_data1 (alu_in_0),
        .mul_data2 (alu_in_1),
        .mul_add_a (mul_add_a),
        .mul_add_b (mul_add_b)
    );

    div_unit u_div (
        .clk        (clk),
        .rst_n      (rst_n),
        .div_start  (div_start),
        .div_op     (div_op),
        .dividend   (alu_in_0),
        .divisor    (alu_in_1),
        .quotient   (quotient),
        .remainder  (remainder),
        .div_finish (div_finish)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_busy <= 1'b0;
        end else if (div_start && !div_finish) begin
            div_busy <= 1'b1;
        end else if (div_finish) begin
            div_busy <= 1'b0;
        end
    end

    assign shamt_imm = alu_in_0[rv_word_pkg::SHAMT_WIDTH-1:0];
    assign shamt_reg = alu_in_1[rv_word_pkg::SHAMT_WIDTH-1:0];

    always_comb begin
        case (alu_op)
            alu_op_pkg::ALU_OP_ADDI,
            alu_op_pkg::ALU_OP_ADD:   alu_out = alu_in_0 + alu_in_1;
            alu_op_pkg::ALU_OP_SUB:   alu_out = alu_in_0 - alu_in_1;
            alu_op_pkg::ALU_OP_SLTI:
                alu_out = rv_word_pkg::word_t'($signed(alu_in_1) < $signed(alu_in_0));
            alu_op_pkg::ALU_OP_SLTIU: alu_out = rv_word_pkg::word_t'(alu_in_1 < alu_in_0);
            alu_op_pkg::ALU_OP_SLT:
                alu_out = rv_word_pkg::word_t'($signed(alu_in_0) < $signed(alu_in_1));
            alu_op_pkg::ALU_OP_SLTU:  alu_out = rv_word_pkg::word_t'(alu_in_0 < alu_in_1);
            alu_op_pkg::ALU_OP_ANDI,
            alu_op_pkg::ALU_OP_AND:   alu_out = alu_in_0 & alu_in_1;
            alu_op_pkg::ALU_OP_ORI,
            alu_op_pkg::ALU_OP_OR:    alu_out = alu_in_0 | alu_in_1;
            alu_op_pkg::ALU_OP_XORI,
            alu_op_pkg::ALU_OP_XOR:   alu_out = alu_in_0 ^ alu_in_1;
            alu_op_pkg::ALU_OP_SLLI:  alu_out = alu_in_1 << shamt_imm;
            alu_op_pkg::ALU_OP_SRLI:  alu_out = alu_in_1 >> shamt_imm;
            alu_op_pkg::ALU_OP_SRAI:  alu_out = rv_word_pkg::word_t'($signed(alu_in_1) >>> shamt_imm);
            alu_op_pkg::ALU_OP_SLL:   alu_out = alu_in_0 << shamt_reg;
            alu_op_pkg::ALU_OP_SRL:   alu_out = alu_in_0 >> shamt_reg;
            alu_op_pkg::ALU_OP_SRA:   alu_out = rv_word_pkg::word_t'($signed(alu_in_0) >>> shamt_reg);
            alu_op_pkg::ALU_OP_LUI:   alu_out = alu_in_0;  // immediate arrives pre-shifted
            alu_op_pkg::ALU_OP_AUIPC: alu_out = alu_in_1 + (alu_in_0 << 12);
            alu_op_pkg::ALU_OP_MUL:   alu_out = mul_sum[rv_word_pkg::WORD_WIDTH-1:0];
            alu_op_pkg::ALU_OP_MULH,
            alu_op_pkg::ALU_OP_MULHSU,
            alu_op_pkg::ALU_OP_MULHU:
                alu_out = mul_sum[2*rv_word_pkg::WORD_WIDTH-1:rv_word_pkg::WORD_WIDTH];
            alu_op_pkg::ALU_OP_DIV,
            alu_op_pkg::ALU_OP_DIVU:  alu_out = div_finish ? quotient : '0;
            alu_op_pkg::ALU_OP_REM,
            alu_op_pkg::ALU_OP_REMU:  alu_out = div_finish ? remainder : '0;
            default:                  alu_out = '0;
        endcase
    end

    // pipeline must hold the divide op for the whole stall
    a_stall_only_on_div: assert property (
        @(posedge clk) disable iff (!rst_n)
        div_in_alu |-> (div_op != alu_op_pkg::DIV_OP_NOP)
    );

    a_finish_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        div_finish |-> div_busy
    );

endmodule

// ==== include/alu_model.svh ====
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// immediate forms carry the immediate in a and rs1 in b
function automatic rv_word_pkg::word_t alu_ref(
    input alu_op_pkg::alu_op_e op,
    input rv_word_pkg::word_t  a,
    input rv_word_pkg::word_t  b
);
    logic [63:0]        ext_a;
    logic [63:0]        ext_b;
    logic [63:0]        prod;
    logic               sign_a;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic               div_zero;
    logic               div_ovf;
    rv_word_pkg::word_t res;

    sign_a   = (op == alu_op_pkg::ALU_OP_MULH) || (op == alu_op_pkg::ALU_OP_MULHSU);
    ext_a    = {{32{a[31] && sign_a}}, a};
    ext_b    = {{32{b[31] && (op == alu_op_pkg::ALU_OP_MULH)}}, b};
    prod     = ext_a * ext_b;
    sa       = a;
    sb       = b;
    div_zero = (b == 32'h0000_0000);
    div_ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);

    case (op)
        alu_op_pkg::ALU_OP_ADDI,
        alu_op_pkg::ALU_OP_ADD:    res = a + b;
        alu_op_pkg::ALU_OP_SUB:    res = a - b;
        alu_op_pkg::ALU_OP_SLTI:   res = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
        alu_op_pkg::ALU_OP_SLTIU:  res = (b < a) ? 32'd1 : 32'd0;
        alu_op_pkg::ALU_OP_SLT:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        alu_op_pkg::ALU_OP_SLTU:   res = (a < b) ? 32'd1 : 32'd0;
        alu_op_pkg::ALU_OP_ANDI,
        alu_op_pkg::ALU_OP_AND:    res = a & b;
        alu_op_pkg::ALU_OP_ORI,
        alu_op_pkg::ALU_OP_OR:     res = a | b;
        alu_op_pkg::ALU_OP_XORI,
        alu_op_pkg::ALU_OP_XOR:    res = a ^ b;
        alu_op_pkg::ALU_OP_SLLI:   res = b << a[4:0];
        alu_op_pkg::ALU_OP_SRLI:   res = b >> a[4:0];
        alu_op_pkg::ALU_OP_SRAI:   res = $signed(b) >>> a[4:0];
        alu_op_pkg::ALU_OP_SLL:    res = a << b[4:0];
        alu_op_pkg::ALU_OP_SRL:    res = a >> b[4:0];
        alu_op_pkg::ALU_OP_SRA:    res = $signed(a) >>> b[4:0];
        alu_op_pkg::ALU_OP_LUI:    res = a;
        alu_op_pkg::ALU_OP_AUIPC:  res = b + (a << 12);
        alu_op_pkg::ALU_OP_MUL:    res = prod[31:0];
        alu_op_pkg::ALU_OP_MULH,
        alu_op_pkg::ALU_OP_MULHSU,
        alu_op_pkg::ALU_OP_MULHU:  res = prod[63:32];
        alu_op_pkg::ALU_OP_DIV:    res = div_zero ? 32'hffff_ffff :
                                         div_ovf ? a : rv_word_pkg::word_t'(sa / sb);
        alu_op_pkg::ALU_OP_DIVU:   res = div_zero ? 32'hffff_ffff : a / b;
        alu_op_pkg::ALU_OP_REM:    res = div_zero ? a :
                                         div_ovf ? 32'd0 : rv_word_pkg::word_t'(sa % sb);
        alu_op_pkg::ALU_OP_REMU:   res = div_zero ? a : a % b;
        default:                   res = 32'd0;
    endcase
    return res;
endfunction

`endif

// ==== test/alu_tb.sv ====
`timescale 1ns/1ps

module alu_tb;

    `include "alu_model.svh"

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 4;
    localparam logic [31:0] LFSR_SEED = 32'd15489;
    localparam logic [31:0] LFSR_TAPS = 32'hB4BC_D35C;  // maximal length right-shifting taps

    localparam int RESET_VECTORS = 3;
    localparam int EDGE_COUNT    = 6;
    localparam int RAND_PER_OP   = 16;
    localparam int COMB_OP_COUNT = 25;  // addi through mulhu
    localparam int DIV_OP_COUNT  = 4;
    localparam int RAND_DIVS     = 32;
    localparam int CHAINED_PAIRS = 2;

    localparam int DIV_STALL_CYCLES = 33;
    localparam int DIV_CYCLES       = 35;
    localparam int COMB_VECTORS     = RESET_VECTORS
                                    + COMB_OP_COUNT * (EDGE_COUNT * EDGE_COUNT + RAND_PER_OP);
    localparam int TOTAL_DIVS       = RAND_DIVS + 2 * DIV_OP_COUNT + 2 * CHAINED_PAIRS;
    localparam int MARGIN_CYCLES    = 200;
    localparam int TEST_CYCLES      = RESET_CYCLES + COMB_VECTORS
                                    + DIV_CYCLES * TOTAL_DIVS + MARGIN_CYCLES;

    logic                clk;
    logic                rst_n;
    alu_op_pkg::alu_op_e alu_op;
    rv_word_pkg::word_t  alu_in_0;
    rv_word_pkg::word_t  alu_in_1;
    rv_word_pkg::word_t  alu_out;
    logic                div_in_alu;

    logic [31:0]         lfsr_state;
    logic                exp_valid;
    rv_word_pkg::word_t  exp_out;
    logic                exp_stall;
    int                  check_count;

    alu UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .alu_op     (alu_op),
        .alu_in_0   (alu_in_0),
        .alu_in_1   (alu_in_1),
        .alu_out    (alu_out),
        .div_in_alu (div_in_alu)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output rv_word_pkg::word_t w);
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    function automatic rv_word_pkg::word_t edge_word(input int idx);
        case (idx)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'h0000_001f;  // largest shift amount
            3:       return 32'h7fff_ffff;
            4:       return 32'h8000_0000;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    task automatic check_value(
        input string              name,
        input rv_word_pkg::word_t actual,
        input rv_word_pkg::word_t expected
    );
        if (actual !== expected) begin
            $display("Mismatch on %s: got 0x%08h, expected 0x%08h (op %s, time %0t)",
                     name, actual, expected, alu_op.name(), $time);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic apply_comb(
        input alu_op_pkg::alu_op_e op,
        input rv_word_pkg::word_t  a,
        input rv_word_pkg::word_t  b
    );
        @(posedge clk);
        alu_op    <= op;
        alu_in_0  <= a;
        alu_in_1  <= b;
        exp_valid <= 1'b1;
        exp_out   <= alu_ref(op, a, b);
        exp_stall <= 1'b0;
    endtask

    // op is held through the stall and the result shows in the 34th cycle
    task automatic apply_div(
        input alu_op_pkg::alu_op_e op,
        input rv_word_pkg::word_t  a,
        input rv_word_pkg::word_t  b
    );
        rv_word_pkg::word_t result;

        result = alu_ref(op, a, b);
        @(posedge clk);
        alu_op    <= op;
        alu_in_0  <= a;
        alu_in_1  <= b;
        exp_valid <= 1'b1;
        exp_out   <= '0;
        exp_stall <= 1'b1;
        repeat (DIV_STALL_CYCLES) @(posedge clk);
        exp_out   <= result;
        exp_stall <= 1'b0;
    endtask

    // outputs settle between the driving edge and the falling edge
    always @(negedge clk) begin
        if (exp_valid) begin
            check_value("alu_out", alu_out, exp_out);
            check_value("div_in_alu", rv_word_pkg::word_t'(div_in_alu),
                        rv_word_pkg::word_t'(exp_stall));
            check_count = check_count + 1;
        end
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", TEST_CYCLES);
        $display("Some tests failed");
        $fatal(1);
    end

    initial begin
        rv_word_pkg::word_t  a;
        rv_word_pkg::word_t  b;
        rv_word_pkg::word_t  sel;
        alu_op_pkg::alu_op_e op;

        lfsr_state  = LFSR_SEED;
        check_count = 0;
        rst_n       = 1'b0;
        alu_op      = alu_op_pkg::ALU_OP_NOP;
        alu_in_0    = '0;
        alu_in_1    = '0;
        exp_valid   = 1'b0;
        exp_out     = '0;
        exp_stall   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < RESET_VECTORS; i++) begin
            draw_bits(32, a);
            draw_bits(32, b);
            apply_comb(alu_op_pkg::ALU_OP_NOP, a, b);
        end

        for (int k = 0; k < COMB_OP_COUNT; k++) begin
            op = alu_op_pkg::alu_op_e'(int'(alu_op_pkg::ALU_OP_ADDI) + k);
            for (int i = 0; i < EDGE_COUNT; i++) begin
                for (int j = 0; j < EDGE_COUNT; j++) begin
                    apply_comb(op, edge_word(i), edge_word(j));
                end
            end
            for (int i = 0; i < RAND_PER_OP; i++) begin
                draw_bits(32, a);
                draw_bits(32, b);
                apply_comb(op, a, b);
            end
        end

        for (int i = 0; i < RAND_DIVS; i++) begin
            draw_bits(2, sel);
            op = alu_op_pkg::alu_op_e'(int'(alu_op_pkg::ALU_OP_DIV) + int'(sel));
            draw_bits(32, a);
            draw_bits(32, b);
            draw_bits(5, sel);
            b = rv_word_pkg::word_t'($signed(b) >>> sel[4:0]);  // spread divisor sizes
            apply_div(op, a, b);
        end

        for (int k = 0; k < DIV_OP_COUNT; k++) begin
            op = alu_op_pkg::alu_op_e'(int'(alu_op_pkg::ALU_OP_DIV) + k);
            draw_bits(32, a);
            apply_div(op, a, '0);
            apply_div(op, 32'h8000_0000, 32'hffff_ffff);
        end

        for (int i = 0; i < CHAINED_PAIRS; i++) begin
            draw_bits(32, a);
            draw_bits(32, b);
            apply_div(alu_op_pkg::ALU_OP_DIV, a, b);
            draw_bits(32, a);
            draw_bits(32, b);
            apply_div(alu_op_pkg::ALU_OP_DIV, a, b);  // second start right after finish
        end

        apply_comb(alu_op_pkg::ALU_OP_NOP, '0, '0);
        repeat (2) @(posedge clk);

        if (check_count > 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1, "the compare process ran no checks");
        end
    end

endmodule

// ==== compile.f ====
+incdir+include
logic/rv_word_pkg.sv
logic/alu_op_pkg.sv
logic/mul_unit.sv
logic/div_unit.sv
logic/alu.sv
test/alu_tb.sv

// ==== Bender.yml ====
package:
  name: rv32im_alu

sources:
  - files:
      - logic/rv_word_pkg.sv
      - logic/alu_op_pkg.sv
      - logic/mul_unit.sv
      - logic/div_unit.sv
      - logic/alu.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/alu_tb.sv
